// File: src/vectrex_glue_pkg.sv
`default_nettype none

package vectrex_glue_pkg;

	// status word bits from the menu
	localparam int ST_RESET      = 0;
	localparam int ST_FRAME      = 2;
	localparam int ST_SKIP_LOGO  = 3;
	localparam int ST_SWAP       = 4;
	localparam int ST_MENU_RESET = 6;

	// joystick byte, buttons sit in bits 4 to 7
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_BTN   = 4;

	// player 2 fields in the keyboard word
	localparam int KB_P2_BASE     = 8;
	localparam int KB_P2_BTN_BASE = 12;

	// pot levels seen by the core
	localparam logic [7:0] POT_CENTER = 8'h00;
	localparam logic [7:0] POT_LOW    = 8'h80;
	localparam logic [7:0] POT_HIGH   = 8'h7f;

	// red level of the frame line
	localparam logic [3:0] FRAME_RED = 4'h4;

endpackage

`default_nettype wire

// File: src/input_mapper.sv
`default_nettype none

module input_mapper import vectrex_glue_pkg::*; (
	input  logic        clk_24,
	input  logic        reset,
	input  logic [7:0]  joystick_0,
	input  logic [7:0]  joystick_1,
	input  logic [15:0] kbjoy,
	input  logic        swap_players,
	output logic [7:0]  pot_x_1,
	output logic [7:0]  pot_y_1,
	output logic [7:0]  pot_x_2,
	output logic [7:0]  pot_y_2,
	output logic [3:0]  btn1,
	output logic [3:0]  btn2
);

	logic [3:0] dir_p1;
	logic [3:0] dir_p2;
	logic [3:0] btn1_next;
	logic [3:0] btn2_next;

	// first argument pair takes priority over the second
	function automatic logic [7:0] pot_level(
		input logic       win,
		input logic [7:0] win_level,
		input logic       lose,
		input logic [7:0] lose_level
	);
		logic [7:0] level;
		level = POT_CENTER;
		if (win)
			level = win_level;
		else if (lose)
			level = lose_level;
		return level;
	endfunction

	// joystick 0 drives the core's second controller
	assign dir_p2 = joystick_0[3:0] | kbjoy[3:0];
	assign dir_p1 = joystick_1[3:0] | kbjoy[KB_P2_BASE +: 4];

	assign btn1_next = joystick_0[JOY_BTN +: 4] | kbjoy[JOY_BTN +: 4] |
		(swap_players ? joystick_1[JOY_BTN +: 4] : 4'b0000);
	assign btn2_next = kbjoy[KB_P2_BTN_BASE +: 4] |
		(swap_players ? 4'b0000 : joystick_1[JOY_BTN +: 4]);

	always_ff @(posedge clk_24) begin
		if (reset) begin
			pot_x_1 <= POT_CENTER;
			pot_y_1 <= POT_CENTER;
			pot_x_2 <= POT_CENTER;
			pot_y_2 <= POT_CENTER;
			btn1    <= 4'b0000;
			btn2    <= 4'b0000;
		end else begin
			// right beats left, down beats up
			pot_x_1 <= pot_level(dir_p1[JOY_RIGHT], POT_HIGH, dir_p1[JOY_LEFT], POT_LOW);
			pot_y_1 <= pot_level(dir_p1[JOY_DOWN], POT_LOW, dir_p1[JOY_UP], POT_HIGH);
			pot_x_2 <= pot_level(dir_p2[JOY_RIGHT], POT_HIGH, dir_p2[JOY_LEFT], POT_LOW);
			pot_y_2 <= pot_level(dir_p2[JOY_DOWN], POT_LOW, dir_p2[JOY_UP], POT_HIGH);
			btn1    <= btn1_next;
			btn2    <= btn2_next;
		end
	end

endmodule

`default_nettype wire

// File: src/cart_rom.sv
`default_nettype none

module cart_rom #(
	parameter int CART_AW = 14
) (
	input  logic               clk_24,
	input  logic               download,
	input  logic               wr,
	input  logic [CART_AW-1:0] waddr,
	input  logic [7:0]         wdata,
	input  logic               rd,
	input  logic [CART_AW-1:0] raddr,
	output logic [7:0]         q
);

	localparam int DEPTH = 2 ** CART_AW;

	logic [7:0]         mem [0:DEPTH-1];
	logic [CART_AW-1:0] addr;
	logic               we;
	logic               re;

	// one port, the download owns it while active
	assign addr = download ? waddr : raddr;
	assign we   = download & wr;
	assign re   = ~download & rd;

	always_ff @(posedge clk_24) begin
		if (we)
			mem[addr] <= wdata;
	end

	// q holds between reads
	always_ff @(posedge clk_24) begin
		if (re)
			q <= mem[addr];
	end

endmodule

`default_nettype wire

// File: src/reset_sequencer.sv
`default_nettype none

module reset_sequencer import vectrex_glue_pkg::*; #(
	parameter int unsigned SKIP_DELAY = 5000000,
	parameter int unsigned SKIP_PULSE = 1000
) (
	input  logic        clk_24,
	input  logic        reset,
	input  logic [31:0] status,
	input  logic        menu_button,
	input  logic        download,
	output logic        core_reset
);

	localparam int CNT_W = $clog2(SKIP_DELAY + 1);
	localparam logic [CNT_W-1:0] DELAY_LOAD = CNT_W'(SKIP_DELAY);
	localparam logic [CNT_W-1:0] PULSE_TOP  = CNT_W'(SKIP_PULSE);

	logic [CNT_W-1:0] skip_count;
	logic             second_reset;

	// timer armed by a download with skip-logo set
	always_ff @(posedge clk_24) begin
		if (reset) begin
			skip_count <= '0;
		end else if (download && status[ST_SKIP_LOGO]) begin
			skip_count <= DELAY_LOAD;
		end else if (!download && skip_count != '0) begin
			skip_count <= skip_count - CNT_W'(1);
		end
	end

	// last stretch of the count resets the core again
	assign second_reset = (skip_count != '0) && (skip_count < PULSE_TOP);

	always_ff @(posedge clk_24) begin
		if (reset) begin
			core_reset <= 1'b1;
		end else begin
			core_reset <= status[ST_RESET] | status[ST_MENU_RESET] | menu_button |
				download | second_reset;
		end
	end

endmodule

`default_nettype wire

// File: src/video_overlay.sv
`default_nettype none

module video_overlay import vectrex_glue_pkg::*; (
	input  logic       clk_24,
	input  logic       reset,
	input  logic       show_frame,
	input  logic       frame_line,
	input  logic       hblank,
	input  logic       vblank,
	input  logic [3:0] r_in,
	input  logic [3:0] g_in,
	input  logic [3:0] b_in,
	output logic [3:0] r_out,
	output logic [3:0] g_out,
	output logic [3:0] b_out
);

	logic blank;
	logic overlay;

	assign blank   = hblank | vblank;
	assign overlay = show_frame & frame_line;

	always_ff @(posedge clk_24) begin
		if (reset) begin
			r_out <= 4'h0;
			g_out <= 4'h0;
			b_out <= 4'h0;
		end else if (blank) begin
			r_out <= 4'h0;
			g_out <= 4'h0;
			b_out <= 4'h0;
		end else if (overlay) begin
			// frame line drawn in dark red
			r_out <= FRAME_RED;
			g_out <= 4'h0;
			b_out <= 4'h0;
		end else begin
			r_out <= r_in;
			g_out <= g_in;
			b_out <= b_in;
		end
	end

endmodule

`default_nettype wire

// File: src/audio_dac.sv
`default_nettype none

module audio_dac #(
	parameter int AUDIO_W = 10
) (
	input  logic               clk_24,
	input  logic               reset,
	input  logic [AUDIO_W-1:0] sample,
	output logic               bitstream
);

	logic [AUDIO_W-1:0] acc;
	logic [AUDIO_W:0]   sum;

	// carry out of the accumulator is the pulse density
	assign sum = {1'b0, acc} + {1'b0, sample};

	always_ff @(posedge clk_24) begin
		if (reset) begin
			acc       <= '0;
			bitstream <= 1'b0;
		end else begin
			acc       <= sum[AUDIO_W-1:0];
			bitstream <= sum[AUDIO_W];
		end
	end

endmodule

`default_nettype wire

// File: src/platform_top.sv
`default_nettype none

module platform_top import vectrex_glue_pkg::*; #(
	parameter int          CART_AW    = 14,
	parameter int unsigned SKIP_DELAY = 5000000,
	parameter int unsigned SKIP_PULSE = 1000,
	parameter int          AUDIO_W    = 10
) (
	input  logic               clk_24,
	input  logic               reset,
	input  logic               ioctl_download,
	input  logic               ioctl_wr,
	input  logic [24:0]        ioctl_addr,
	input  logic [7:0]         ioctl_dout,
	input  logic [31:0]        status,
	input  logic [1:0]         buttons,
	input  logic [7:0]         joystick_0,
	input  logic [7:0]         joystick_1,
	input  logic [15:0]        kbjoy,
	input  logic               cart_rd,
	input  logic [CART_AW-1:0] cart_addr,
	output logic [7:0]         cart_do,
	output logic               core_reset,
	output logic [7:0]         pot_x_1,
	output logic [7:0]         pot_y_1,
	output logic [7:0]         pot_x_2,
	output logic [7:0]         pot_y_2,
	output logic [3:0]         btn1,
	output logic [3:0]         btn2,
	input  logic [3:0]         rr,
	input  logic [3:0]         gg,
	input  logic [3:0]         bb,
	input  logic               hb,
	input  logic               vb,
	input  logic               frame_line,
	output logic [3:0]         vid_r,
	output logic [3:0]         vid_g,
	output logic [3:0]         vid_b,
	input  logic [AUDIO_W-1:0] audio,
	output logic               audio_out,
	output logic               led
);

	// led is lit while no download runs
	assign led = ~ioctl_download;

	input_mapper u_input_mapper (
		.clk_24       (clk_24),
		.reset        (reset),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.kbjoy        (kbjoy),
		.swap_players (status[ST_SWAP]),
		.pot_x_1      (pot_x_1),
		.pot_y_1      (pot_y_1),
		.pot_x_2      (pot_x_2),
		.pot_y_2      (pot_y_2),
		.btn1         (btn1),
		.btn2         (btn2)
	);

	cart_rom #(.CART_AW(CART_AW)) u_cart_rom (
		.clk_24   (clk_24),
		.download (ioctl_download),
		.wr       (ioctl_wr),
		.waddr    (ioctl_addr[CART_AW-1:0]),
		.wdata    (ioctl_dout),
		.rd       (cart_rd),
		.raddr    (cart_addr),
		.q        (cart_do)
	);

	reset_sequencer #(
		.SKIP_DELAY (SKIP_DELAY),
		.SKIP_PULSE (SKIP_PULSE)
	) u_reset_sequencer (
		.clk_24      (clk_24),
		.reset       (reset),
		.status      (status),
		.menu_button (buttons[1]),
		.download    (ioctl_download),
		.core_reset  (core_reset)
	);

	video_overlay u_video_overlay (
		.clk_24     (clk_24),
		.reset      (reset),
		.show_frame (status[ST_FRAME]),
		.frame_line (frame_line),
		.hblank     (hb),
		.vblank     (vb),
		.r_in       (rr),
		.g_in       (gg),
		.b_in       (bb),
		.r_out      (vid_r),
		.g_out      (vid_g),
		.b_out      (vid_b)
	);

	audio_dac #(.AUDIO_W(AUDIO_W)) u_audio_dac (
		.clk_24    (clk_24),
		.reset     (reset),
		.sample    (audio),
		.bitstream (audio_out)
	);

endmodule

`default_nettype wire

// File: tb/platform_props.sv
`default_nettype none

module platform_props #(
	parameter int unsigned SKIP_PULSE = 1000
) (
	input logic clk_24,
	input logic reset,
	input logic download,
	input logic core_reset,
	input logic second_reset
);

	timeunit 1ns;
	timeprecision 100ps;

	int unsigned run_len;

	// cycles the second reset has been high so far
	always_ff @(posedge clk_24) begin
		if (reset || !second_reset)
			run_len <= 0;
		else
			run_len <= run_len + 1;
	end

	a_download_resets: assert property (@(posedge clk_24) disable iff (reset)
		download |=> core_reset)
		else $error("core_reset not high the cycle after download");

	a_no_start_in_download: assert property (@(posedge clk_24) disable iff (reset)
		$rose(second_reset) |-> !download)
		else $error("second reset started while download was high");

	a_pulse_length: assert property (@(posedge clk_24) disable iff (reset)
		$fell(second_reset) |-> run_len == SKIP_PULSE - 1)
		else $error("second reset pulse lasted %0d cycles", run_len);

endmodule

`default_nettype wire

// File: tb/platform_checker.sv
`default_nettype none

module platform_checker (
	input logic        clk_24,
	input logic        chk_vec,
	input logic [31:0] exp_pots,
	input logic [7:0]  exp_btns,
	input logic [11:0] exp_vid,
	input logic [7:0]  pot_x_1,
	input logic [7:0]  pot_y_1,
	input logic [7:0]  pot_x_2,
	input logic [7:0]  pot_y_2,
	input logic [3:0]  btn1,
	input logic [3:0]  btn2,
	input logic [3:0]  vid_r,
	input logic [3:0]  vid_g,
	input logic [3:0]  vid_b
);

	timeunit 1ns;
	timeprecision 100ps;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int errors_at_start = 0;

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic fail(input string what);
		$display("error at %0t: %s", $time, what);
		errors++;
	endtask

	task automatic start_test();
		errors_at_start = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != errors_at_start) begin
			tests_failed++;
			$display("test %-32s failed", name);
		end else begin
			$display("test %-32s ok", name);
		end
	endtask

	task automatic report();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
	endtask

	// outputs settle at the rising edge, so look at the falling one
	always @(negedge clk_24) begin
		if (chk_vec) begin
			compare("pot_x_1", {24'h0, exp_pots[31:24]}, {24'h0, pot_x_1});
			compare("pot_y_1", {24'h0, exp_pots[23:16]}, {24'h0, pot_y_1});
			compare("pot_x_2", {24'h0, exp_pots[15:8]}, {24'h0, pot_x_2});
			compare("pot_y_2", {24'h0, exp_pots[7:0]}, {24'h0, pot_y_2});
			compare("btn1", {28'h0, exp_btns[7:4]}, {28'h0, btn1});
			compare("btn2", {28'h0, exp_btns[3:0]}, {28'h0, btn2});
			compare("vid_r", {28'h0, exp_vid[11:8]}, {28'h0, vid_r});
			compare("vid_g", {28'h0, exp_vid[7:4]}, {28'h0, vid_g});
			compare("vid_b", {28'h0, exp_vid[3:0]}, {28'h0, vid_b});
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_platform.sv
`default_nettype none

module tb_platform import vectrex_glue_pkg::*; ;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CART_AW = 14;
	localparam int unsigned SKIP_DELAY = 300;
	localparam int unsigned SKIP_PULSE = 40;
	localparam int AUDIO_W = 10;
	localparam int NUM_VEC = 14;
	localparam int NUM_BYTES = 64;
	localparam int WATCHDOG_CYCLES = NUM_VEC * 4 + 3 * 1040 + 2 * (SKIP_DELAY + 120) +
		4 * NUM_BYTES + 3000;

	// inputs, then expected pots {x1,y1,x2,y2}, buttons {btn1,btn2} and colour
	typedef struct packed {
		logic [7:0]  joy0;
		logic [7:0]  joy1;
		logic [15:0] kb;
		logic        swap;
		logic        frame;
		logic        fl;
		logic        hblank;
		logic        vblank;
		logic [11:0] rgb;
		logic [31:0] pots;
		logic [7:0]  btns;
		logic [11:0] vid;
	} vec_t;

	vec_t vecs [NUM_VEC];

	logic clk_24 = 1'b0;
	logic reset, ioctl_download, ioctl_wr, cart_rd, hb, vb, frame_line;
	logic [24:0] ioctl_addr;
	logic [7:0] ioctl_dout, joystick_0, joystick_1, cart_do;
	logic [31:0] status;
	logic [1:0] buttons;
	logic [15:0] kbjoy;
	logic [CART_AW-1:0] cart_addr;
	logic core_reset, audio_out, led;
	logic [7:0] pot_x_1, pot_y_1, pot_x_2, pot_y_2;
	logic [3:0] btn1, btn2, rr, gg, bb, vid_r, vid_g, vid_b;
	logic [AUDIO_W-1:0] audio;

	logic chk_vec = 1'b0;
	logic [31:0] exp_pots;
	logic [7:0] exp_btns;
	logic [11:0] exp_vid;

	int seed = 32'h3882_736d;
	int cycle = 0;
	logic [7:0] rom_data [NUM_BYTES];
	logic [CART_AW-1:0] rom_addr [NUM_BYTES];

	always #5 clk_24 = ~clk_24;

	always @(posedge clk_24)
		cycle <= cycle + 1;

	platform_top #(
		.CART_AW    (CART_AW),
		.SKIP_DELAY (SKIP_DELAY),
		.SKIP_PULSE (SKIP_PULSE),
		.AUDIO_W    (AUDIO_W)
	) DUT (.*);

	platform_checker chk (.*);

	bind reset_sequencer platform_props #(.SKIP_PULSE(SKIP_PULSE)) u_props (
		.clk_24       (clk_24),
		.reset        (reset),
		.download     (download),
		.core_reset   (core_reset),
		.second_reset (second_reset)
	);

	task automatic next_cycle();
		@(posedge clk_24);
		#1;
	endtask

	task automatic apply_reset(input int n);
		reset = 1'b1;
		repeat (n) next_cycle();
		reset = 1'b0;
	endtask

	// count ones over 1024 cycles right after reset
	task automatic run_audio(input int unsigned s);
		int unsigned ones;
		ones = 0;
		chk.start_test();
		audio = s[AUDIO_W-1:0];
		apply_reset(2);
		repeat (1024) begin
			next_cycle();
			ones += audio_out;
		end
		chk.compare("audio_out ones", s, ones);
		chk.end_test($sformatf("audio density %0d", s));
	endtask

	task automatic run_vector(input int i);
		vec_t v;
		v = vecs[i];
		chk.start_test();
		joystick_0 = v.joy0;
		joystick_1 = v.joy1;
		kbjoy = v.kb;
		status = '0;
		status[ST_SWAP] = v.swap;
		status[ST_FRAME] = v.frame;
		frame_line = v.fl;
		hb = v.hblank;
		vb = v.vblank;
		{rr, gg, bb} = v.rgb;
		next_cycle();
		exp_pots = v.pots;
		exp_btns = v.btns;
		exp_vid = v.vid;
		chk_vec = 1'b1;
		next_cycle();
		chk_vec = 1'b0;
		chk.end_test($sformatf("vector %0d", i));
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_24);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int fall_cycle;
		int delay;
		int len;
		logic stray;

		vecs[0]  = '{8'h01, 8'h00, 16'h0000, 0, 0, 0, 0, 0, 12'h123, 32'h0000_7f00, 8'h00, 12'h123};
		vecs[1]  = '{8'h02, 8'h00, 16'h0000, 0, 0, 0, 1, 0, 12'h123, 32'h0000_8000, 8'h00, 12'h000};
		vecs[2]  = '{8'h03, 8'h00, 16'h0000, 0, 0, 0, 0, 1, 12'h123, 32'h0000_7f00, 8'h00, 12'h000};
		vecs[3]  = '{8'h04, 8'h00, 16'h0000, 0, 1, 0, 0, 0, 12'h5a5, 32'h0000_0080, 8'h00, 12'h5a5};
		vecs[4]  = '{8'h08, 8'h00, 16'h0000, 0, 1, 1, 0, 0, 12'h5a5, 32'h0000_007f, 8'h00, 12'h400};
		vecs[5]  = '{8'h0c, 8'h00, 16'h0000, 0, 0, 1, 0, 0, 12'h9bc, 32'h0000_0080, 8'h00, 12'h9bc};
		vecs[6]  = '{8'h00, 8'h01, 16'h0000, 0, 1, 1, 1, 0, 12'hfff, 32'h7f00_0000, 8'h00, 12'h000};
		vecs[7]  = '{8'h00, 8'h0a, 16'h0000, 0, 0, 0, 0, 0, 12'h0f0, 32'h807f_0000, 8'h00, 12'h0f0};
		vecs[8]  = '{8'h00, 8'h00, 16'h0500, 0, 0, 0, 0, 0, 12'h00f, 32'h7f80_0000, 8'h00, 12'h00f};
		vecs[9]  = '{8'h00, 8'h00, 16'h0006, 0, 0, 0, 0, 0, 12'h321, 32'h0000_8080, 8'h00, 12'h321};
		vecs[10] = '{8'h10, 8'h20, 16'h1040, 0, 0, 0, 0, 0, 12'h000, 32'h0000_0000, 8'h53, 12'h000};
		vecs[11] = '{8'h10, 8'h20, 16'h1040, 1, 0, 0, 0, 0, 12'h000, 32'h0000_0000, 8'h71, 12'h000};
		vecs[12] = '{8'h00, 8'hf1, 16'h0000, 1, 1, 1, 0, 0, 12'h777, 32'h7f00_0000, 8'hf0, 12'h400};
		vecs[13] = '{8'h00, 8'h00, 16'h0000, 0, 0, 0, 0, 0, 12'habc, 32'h0000_0000, 8'h00, 12'habc};

		for (int i = 0; i < NUM_BYTES; i++) begin
			rom_addr[i] = CART_AW'(i * 211 + 17);
			rom_data[i] = 8'($random(seed));
		end

		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		status = '0;
		buttons = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		kbjoy = '0;
		cart_rd = 1'b0;
		cart_addr = '0;
		{rr, gg, bb} = '0;
		{hb, vb, frame_line} = '0;
		audio = '0;

		// reset values, then core_reset drops one cycle after release
		chk.start_test();
		repeat (8) next_cycle();
		chk.compare("core_reset", 1, {31'h0, core_reset});
		chk.compare("pots", 0, {pot_x_1, pot_y_1, pot_x_2, pot_y_2});
		chk.compare("buttons", 0, {24'h0, btn1, btn2});
		chk.compare("video", 0, {20'h0, vid_r, vid_g, vid_b});
		chk.compare("audio_out", 0, {31'h0, audio_out});
		reset = 1'b0;
		next_cycle();
		chk.compare("core_reset", 0, {31'h0, core_reset});
		chk.end_test("reset state");

		run_audio(0);
		run_audio(256);
		run_audio(1023);

		for (int i = 0; i < NUM_VEC; i++)
			run_vector(i);

		// download with skip-logo set
		chk.start_test();
		status = '0;
		status[ST_SKIP_LOGO] = 1'b1;
		ioctl_download = 1'b1;
		next_cycle();
		chk.compare("led", 0, {31'h0, led});
		for (int i = 0; i < NUM_BYTES; i++) begin
			ioctl_addr = {11'h400, rom_addr[i]};
			ioctl_dout = rom_data[i];
			ioctl_wr = 1'b1;
			next_cycle();
			ioctl_wr = 1'b0;
			next_cycle();
			chk.compare("core_reset", 1, {31'h0, core_reset});
		end
		ioctl_download = 1'b0;
		fall_cycle = cycle;
		next_cycle();
		chk.compare("core_reset", 0, {31'h0, core_reset});
		chk.compare("led", 1, {31'h0, led});
		for (int i = 0; i < NUM_BYTES; i++) begin
			cart_rd = 1'b1;
			cart_addr = rom_addr[i];
			next_cycle();
			cart_rd = 1'b0;
			cart_addr = ~rom_addr[i];
			chk.compare("cart_do", {24'h0, rom_data[i]}, {24'h0, cart_do});
			next_cycle();
			chk.compare("cart_do", {24'h0, rom_data[i]}, {24'h0, cart_do});
		end
		chk.end_test("cartridge load and read-back");

		chk.start_test();
		while (!core_reset)
			next_cycle();
		delay = cycle - fall_cycle;
		if (delay < int'(SKIP_DELAY - SKIP_PULSE) - 2 || delay > int'(SKIP_DELAY - SKIP_PULSE) + 2)
			chk.fail($sformatf("second reset began %0d cycles after download", delay));
		len = 0;
		while (core_reset) begin
			len++;
			next_cycle();
		end
		chk.compare("second reset length", SKIP_PULSE - 1, len);
		stray = 1'b0;
		repeat (SKIP_DELAY) begin
			next_cycle();
			stray |= core_reset;
		end
		if (stray)
			chk.fail("core_reset rose again after the second reset");
		chk.end_test("skip logo reset");

		// skip-logo clear, no second reset may follow
		chk.start_test();
		status = '0;
		ioctl_download = 1'b1;
		repeat (4) next_cycle();
		ioctl_download = 1'b0;
		next_cycle();
		stray = 1'b0;
		repeat (SKIP_DELAY + 20) begin
			next_cycle();
			stray |= core_reset;
		end
		if (stray)
			chk.fail("second reset happened with skip-logo clear");
		chk.end_test("no skip logo");

		chk.report();
		if (chk.errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
src/vectrex_glue_pkg.sv
src/input_mapper.sv
src/cart_rom.sv
src/reset_sequencer.sv
src/video_overlay.sv
src/audio_dac.sv
src/platform_top.sv
tb/platform_props.sv
tb/platform_checker.sv
tb/tb_platform.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -sv -Wno-fatal
TOP       = tb_platform
FILELIST  = compile.f
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q -e '\*\*\* TEST FAILED \*\*\*' -e '%Error' $(LOG); then exit 1; fi
	@grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
